/* hw/vp_pkg.sv */
`default_nettype none

package vp_pkg;

	//////////////////////////////////////////////////
	// Bus widths
	localparam int cart_addr_w  = 12;
	localparam int rom_addr_w   = 14;
	localparam int char_addr_w  = 12;
	localparam int ioctl_addr_w = 25;
	localparam int joy_w        = 16;
	localparam int color_w      = 24;
	localparam int size_w       = 16; // Download byte counter

	//////////////////////////////////////////////////
	// Last count of each clock enable divider
	localparam int div_ctr_w = 4;
	localparam logic [div_ctr_w-1:0] cpu_div_ntsc = 4'd7;  // Pulse every 8 clocks
	localparam logic [div_ctr_w-1:0] cpu_div_pal  = 4'd11; // Pulse every 12 clocks
	localparam logic [div_ctr_w-1:0] vdc_div_ntsc = 4'd5;
	localparam logic [div_ctr_w-1:0] vdc_div_pal  = 4'd9;

	// Image sizes that pick a bank layout
	localparam logic [size_w-1:0] size_4k  = 16'd4096;
	localparam logic [size_w-1:0] size_8k  = 16'd8192;
	localparam logic [size_w-1:0] size_16k = 16'd16384;

	// Download index values
	localparam logic [7:0] idx_xrom = 8'd2;
	localparam logic [7:0] idx_char = 8'd3; // VDC font

	// Joystick word bit positions
	localparam int joy_right_bit  = 0;
	localparam int joy_left_bit   = 1;
	localparam int joy_down_bit   = 2;
	localparam int joy_up_bit     = 3;
	localparam int joy_action_bit = 4;
	localparam int joy_reset_bit  = 5;
	localparam int joy_num_lsb    = 6;  // Number keys 1..9, 0
	localparam int joy_num_w      = 10;

	typedef enum logic [2:0] {
		layout_plain,
		layout_4k,
		layout_8k,
		layout_12k, // Banked 16K image
		layout_xrom
	} cart_layout_e;

	//////////////////////////////////////////////////
	// Scancode in 16:8, ASCII in 7:0
	localparam int scan_tab_len = 48;
	localparam logic [16:0] scan_ascii_tab [scan_tab_len] = '{
		{9'h016, "1"}, {9'h01E, "2"}, {9'h026, "3"}, {9'h025, "4"},
		{9'h02E, "5"}, {9'h036, "6"}, {9'h03D, "7"}, {9'h03E, "8"},
		{9'h046, "9"}, {9'h045, "0"}, {9'h01C, "a"}, {9'h032, "b"},
		{9'h021, "c"}, {9'h023, "d"}, {9'h024, "e"}, {9'h02B, "f"},
		{9'h034, "g"}, {9'h033, "h"}, {9'h043, "i"}, {9'h03B, "j"},
		{9'h042, "k"}, {9'h04B, "l"}, {9'h03A, "m"}, {9'h031, "n"},
		{9'h044, "o"}, {9'h04D, "p"}, {9'h015, "q"}, {9'h02D, "r"},
		{9'h01B, "s"}, {9'h02C, "t"}, {9'h03C, "u"}, {9'h02A, "v"},
		{9'h01D, "w"}, {9'h022, "x"}, {9'h035, "y"}, {9'h01A, "z"},
		{9'h029, " "}, {9'h079, "+"}, {9'h07B, "-"}, {9'h07C, "*"},
		{9'h04A, "/"}, {9'h055, "="}, {9'h01F, 8'h11}, {9'h027, 8'h12},
		{9'h05A, 8'd10}, {9'h066, 8'd8}, {9'h000, 8'h00}, {9'h000, 8'h00}
	};

	// Index is {R, G, B, luma}
	localparam logic [color_w-1:0] palette_ntsc [16] = '{
		24'h000000, 24'h676767, 24'h1a37be, 24'h5c80f6,
		24'h006d07, 24'h56c469, 24'h2aaabe, 24'h77e6eb,
		24'h790000, 24'hc75151, 24'h94309f, 24'hdc84e8,
		24'h77670b, 24'hc6b86a, 24'hcecece, 24'hffffff
	};

	localparam logic [color_w-1:0] palette_pal [16] = '{
		24'h000000, 24'h494949, 24'h0000b6, 24'h4949ff,
		24'h00b601, 24'h49ff49, 24'h00b6c9, 24'h49ffff,
		24'hb60000, 24'hff4949, 24'hb600b6, 24'hff49ff,
		24'hb6b600, 24'hffff49, 24'hb6b6b6, 24'hffffff
	};

endpackage

`default_nettype wire

/* hw/vp_clock_enables.sv */
`timescale 1ns/10ps
`default_nettype none

module vp_clock_enables import vp_pkg::*; (
	input wire    clk_sys,
	input wire    reset,
	input wire    pal_i,
	output logic  cpu_en_o,
	output logic  vdc_en_o
);

	logic                 pal_q;
	logic                 mode_chg;
	logic [div_ctr_w-1:0] cpu_ctr;
	logic [div_ctr_w-1:0] vdc_ctr;
	logic [div_ctr_w-1:0] cpu_last;
	logic [div_ctr_w-1:0] vdc_last;

	assign cpu_last = pal_i ? cpu_div_pal : cpu_div_ntsc;
	assign vdc_last = pal_i ? vdc_div_pal : vdc_div_ntsc;
	assign mode_chg = pal_i ^ pal_q;

	// Previous mode for change detection
	always_ff @(posedge clk_sys) begin
		pal_q <= pal_i;
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cpu_ctr  <= '0;
			vdc_ctr  <= '0;
			cpu_en_o <= 1'b0;
			vdc_en_o <= 1'b0;
		end else if (mode_chg) begin
			// NTSC/PAL switch restarts both dividers
			cpu_ctr  <= '0;
			vdc_ctr  <= '0;
			cpu_en_o <= 1'b0;
			vdc_en_o <= 1'b0;
		end else begin
			if (cpu_ctr >= cpu_last) begin
				cpu_ctr  <= '0;
				cpu_en_o <= 1'b1;
			end else begin
				cpu_ctr  <= cpu_ctr + div_ctr_w'(1);
				cpu_en_o <= 1'b0;
			end

			if (vdc_ctr >= vdc_last) begin
				vdc_ctr  <= '0;
				vdc_en_o <= 1'b1;
			end else begin
				vdc_ctr  <= vdc_ctr + div_ctr_w'(1);
				vdc_en_o <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* hw/vp_input_encoder.sv */
`timescale 1ns/10ps
`default_nettype none

module vp_input_encoder import vp_pkg::*; (
	input wire              clk_sys,
	input wire              reset,
	input wire [10:0]       ps2_key_i,      // 10 strobe, 9 pressed, 8:0 code
	input wire [joy_w-1:0]  joy_0_i,
	input wire [joy_w-1:0]  joy_1_i,
	input wire              joy_swap_i,
	output logic            key_ready_o,
	output logic [7:0]      key_ascii_o,
	output logic            key_released_o,
	output logic [1:0]      joy_up_n_o,
	output logic [1:0]      joy_down_n_o,
	output logic [1:0]      joy_left_n_o,
	output logic [1:0]      joy_right_n_o,
	output logic [1:0]      joy_action_n_o,
	output logic            joy_reset_n_o
);

	logic [joy_w-1:0]     joy_a;
	logic [joy_w-1:0]     joy_b;
	logic [joy_num_w-1:0] joy_num;
	logic [joy_num_w-1:0] joy_num_q;
	logic                 ps2_strobe_q;
	logic                 ps2_event;
	logic                 joy_event;
	logic [7:0]           joy_ascii_q;
	logic [7:0]           joy_ascii_nxt;

	// Table lookup on the low 8 bits of the scancode
	function automatic logic [7:0] scan_to_ascii(input logic [7:0] code);
		logic [7:0] res;
		res = 8'h00;
		for (int i = 0; i < scan_tab_len; i++) begin
			if (scan_ascii_tab[i][15:8] == code)
				res = scan_ascii_tab[i][7:0];
		end
		return res;
	endfunction

	// Lowest held number key wins
	function automatic logic [7:0] joy_to_ascii(input logic [joy_num_w-1:0] num);
		logic [7:0] res;
		res = 8'h00;
		for (int i = joy_num_w - 1; i >= 0; i--) begin
			if (num[i])
				res = (i == joy_num_w - 1) ? "0" : 8'(8'h31 + i);
		end
		return res;
	endfunction

	//////////////////////////////////////////////////
	// Pad swap

	assign joy_a = joy_swap_i ? joy_1_i : joy_0_i;
	assign joy_b = joy_swap_i ? joy_0_i : joy_1_i;

	assign joy_num = joy_a[joy_num_lsb +: joy_num_w] | joy_b[joy_num_lsb +: joy_num_w];

	assign ps2_event     = ps2_key_i[10] ^ ps2_strobe_q; // Strobe toggles per key event
	assign joy_event     = |(joy_num ^ joy_num_q);
	assign joy_ascii_nxt = (|joy_num) ? joy_to_ascii(joy_num) : joy_ascii_q;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			ps2_strobe_q   <= 1'b0;
			joy_num_q      <= '0;
			key_ready_o    <= 1'b0;
			key_released_o <= 1'b0;
		end else begin
			ps2_strobe_q   <= ps2_key_i[10];
			joy_num_q      <= joy_num;
			key_ready_o    <= ps2_event | joy_event;
			key_released_o <= ~ps2_key_i[9] & ~(|joy_num);
		end
	end

	// Keyboard event has priority over the pads
	always_ff @(posedge clk_sys) begin
		joy_ascii_q <= joy_ascii_nxt;
		key_ascii_o <= ps2_event ? scan_to_ascii(ps2_key_i[7:0]) : joy_ascii_nxt;
	end

	//////////////////////////////////////////////////
	// Active-low directions with pad A in bit 1 and pad B in bit 0

	assign joy_up_n_o     = ~{joy_a[joy_up_bit], joy_b[joy_up_bit]};
	assign joy_down_n_o   = ~{joy_a[joy_down_bit], joy_b[joy_down_bit]};
	assign joy_left_n_o   = ~{joy_a[joy_left_bit], joy_b[joy_left_bit]};
	assign joy_right_n_o  = ~{joy_a[joy_right_bit], joy_b[joy_right_bit]};
	assign joy_action_n_o = ~{joy_a[joy_action_bit], joy_b[joy_action_bit]};
	assign joy_reset_n_o  = ~(joy_a[joy_reset_bit] & joy_b[joy_reset_bit]); // Both pads

endmodule

`default_nettype wire

/* hw/vp_cart_mapper.sv */
`timescale 1ns/10ps
`default_nettype none

module vp_cart_mapper import vp_pkg::*; (
	input wire                     clk_sys,
	input wire                     reset,
	input wire                     ioctl_download_i,
	input wire                     ioctl_wr_i,
	input wire [7:0]               ioctl_index_i,
	input wire [ioctl_addr_w-1:0]  ioctl_addr_i,
	input wire [cart_addr_w-1:0]   cart_addr_i,
	input wire                     cart_bank0_i,
	input wire                     cart_bank1_i,
	input wire                     cart_psen_n_i,
	input wire                     cart_cs_n_i,
	input wire [char_addr_w-1:0]   char_addr_i,
	output logic [rom_addr_w-1:0]  rom_addr_o,
	output logic                   rom_wren_o,
	output logic                   rom_rden_o,
	output logic [char_addr_w-1:0] char_addr_o,
	output logic                   char_wren_o
);

	logic              dl_q;
	logic [size_w-1:0] cart_size_q;
	logic              xrom_q;
	logic              rom_dl;
	logic              char_dl;
	cart_layout_e      layout;

	assign rom_dl  = ioctl_download_i && (ioctl_index_i[1:0] < idx_char[1:0]);
	assign char_dl = ioctl_download_i && (ioctl_index_i[1:0] == idx_char[1:0]);

	//////////////////////////////////////////////////
	// Download tracking

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			dl_q        <= 1'b0;
			cart_size_q <= '0;
			xrom_q      <= 1'b0;
		end else begin
			dl_q <= ioctl_download_i;
			if (ioctl_download_i && !dl_q) begin // New image starts
				cart_size_q <= '0;
				xrom_q      <= (ioctl_index_i == idx_xrom);
			end else if (ioctl_download_i && ioctl_wr_i) begin
				cart_size_q <= cart_size_q + size_w'(1);
			end
		end
	end

	always_comb begin
		if (xrom_q) begin
			layout = layout_xrom;
		end else begin
			case (cart_size_q)
				size_4k:  layout = layout_4k;
				size_8k:  layout = layout_8k;
				size_16k: layout = layout_12k;
				default:  layout = layout_plain;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Addresses and enables

	always_comb begin
		if (rom_dl) begin
			rom_addr_o = ioctl_addr_i[rom_addr_w-1:0];
		end else begin
			case (layout)
				layout_xrom: rom_addr_o = {2'b00, cart_addr_i};
				layout_4k:   rom_addr_o = {2'b00, cart_bank0_i, cart_addr_i[11], cart_addr_i[9:0]};
				layout_8k:   rom_addr_o = {1'b0, cart_bank1_i, cart_bank0_i, cart_addr_i[11],
					cart_addr_i[9:0]};
				layout_12k:  rom_addr_o = {cart_bank1_i, cart_bank0_i, cart_addr_i};
				default:     rom_addr_o = {3'b000, cart_addr_i[11], cart_addr_i[9:0]}; // A10 unused
			endcase
		end
	end

	assign rom_wren_o  = rom_dl & ioctl_wr_i;
	assign rom_rden_o  = xrom_q ? (cart_psen_n_i & ~(cart_cs_n_i & cart_bank0_i)) : ~cart_psen_n_i;
	assign char_addr_o = char_dl ? {3'b000, ioctl_addr_i[8:0]} : char_addr_i;
	assign char_wren_o = char_dl & ioctl_wr_i;

endmodule

`default_nettype wire

/* hw/vp_palette.sv */
`timescale 1ns/10ps
`default_nettype none

module vp_palette import vp_pkg::*; (
	input wire                 clk_sys,
	input wire                 reset,
	input wire                 pal_colors_i, // 1 selects PAL table
	input wire                 vdc_r_i,
	input wire                 vdc_g_i,
	input wire                 vdc_b_i,
	input wire                 vdc_luma_i,
	output logic [color_w-1:0] color_o
);

	logic [3:0] idx;

	// R is the top index bit
	assign idx = {vdc_r_i, vdc_g_i, vdc_b_i, vdc_luma_i};

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset)
			color_o <= '0; // Black
		else
			color_o <= pal_colors_i ? palette_pal[idx] : palette_ntsc[idx];
	end

endmodule

`default_nettype wire

/* hw/vp_glue_top.sv */
`timescale 1ns/10ps
`default_nettype none

module vp_glue_top import vp_pkg::*; (
	input wire                     clk_sys,
	input wire                     reset,
	input wire                     pal_i,
	input wire                     pal_colors_i,
	input wire                     joy_swap_i,
	input wire [10:0]              ps2_key_i,
	input wire [joy_w-1:0]         joy_0_i,
	input wire [joy_w-1:0]         joy_1_i,
	input wire                     ioctl_download_i,
	input wire                     ioctl_wr_i,
	input wire [7:0]               ioctl_index_i,
	input wire [ioctl_addr_w-1:0]  ioctl_addr_i,
	input wire [cart_addr_w-1:0]   cart_addr_i,
	input wire                     cart_bank0_i,
	input wire                     cart_bank1_i,
	input wire                     cart_psen_n_i,
	input wire                     cart_cs_n_i,
	input wire [char_addr_w-1:0]   char_addr_i,
	input wire                     vdc_r_i,
	input wire                     vdc_g_i,
	input wire                     vdc_b_i,
	input wire                     vdc_luma_i,
	output logic                   cpu_en_o,
	output logic                   vdc_en_o,
	output logic                   key_ready_o,
	output logic [7:0]             key_ascii_o,
	output logic                   key_released_o,
	output logic [1:0]             joy_up_n_o,
	output logic [1:0]             joy_down_n_o,
	output logic [1:0]             joy_left_n_o,
	output logic [1:0]             joy_right_n_o,
	output logic [1:0]             joy_action_n_o,
	output logic                   joy_reset_n_o,
	output logic [rom_addr_w-1:0]  rom_addr_o,
	output logic                   rom_wren_o,
	output logic                   rom_rden_o,
	output logic [char_addr_w-1:0] char_addr_o,
	output logic                   char_wren_o,
	output logic [color_w-1:0]     color_o
);

	//////////////////////////////////////////////////
	// Input side

	vp_input_encoder input_encoder_i (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ps2_key_i      (ps2_key_i),
		.joy_0_i        (joy_0_i),
		.joy_1_i        (joy_1_i),
		.joy_swap_i     (joy_swap_i),
		.key_ready_o    (key_ready_o),
		.key_ascii_o    (key_ascii_o),
		.key_released_o (key_released_o),
		.joy_up_n_o     (joy_up_n_o),
		.joy_down_n_o   (joy_down_n_o),
		.joy_left_n_o   (joy_left_n_o),
		.joy_right_n_o  (joy_right_n_o),
		.joy_action_n_o (joy_action_n_o),
		.joy_reset_n_o  (joy_reset_n_o)
	);

	// Cartridge and font memories sit outside
	vp_cart_mapper cart_mapper_i (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_index_i    (ioctl_index_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.cart_addr_i      (cart_addr_i),
		.cart_bank0_i     (cart_bank0_i),
		.cart_bank1_i     (cart_bank1_i),
		.cart_psen_n_i    (cart_psen_n_i),
		.cart_cs_n_i      (cart_cs_n_i),
		.char_addr_i      (char_addr_i),
		.rom_addr_o       (rom_addr_o),
		.rom_wren_o       (rom_wren_o),
		.rom_rden_o       (rom_rden_o),
		.char_addr_o      (char_addr_o),
		.char_wren_o      (char_wren_o)
	);

	vp_clock_enables clock_enables_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.pal_i    (pal_i),
		.cpu_en_o (cpu_en_o),
		.vdc_en_o (vdc_en_o)
	);

	//////////////////////////////////////////////////
	// Output side

	vp_palette palette_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.pal_colors_i (pal_colors_i),
		.vdc_r_i      (vdc_r_i),
		.vdc_g_i      (vdc_g_i),
		.vdc_b_i      (vdc_b_i),
		.vdc_luma_i   (vdc_luma_i),
		.color_o      (color_o)
	);

endmodule

`default_nettype wire

/* sim/tb_vp_glue.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_vp_glue import vp_pkg::*; ();

	localparam int clk_period = 40;
	localparam int clk_phase_cycles = 108; // NTSC and PAL enable windows

	typedef enum logic [2:0] {
		kind_clk,
		kind_key,
		kind_joy,
		kind_dl,
		kind_map,
		kind_color
	} kind_e;

	typedef struct packed {
		kind_e       kind;
		logic [39:0] stim;
		logic [31:0] want;
	} entry_t;

	logic                    clk_sys;
	logic                    reset;
	logic                    pal_i;
	logic                    pal_colors_i;
	logic                    joy_swap_i;
	logic [10:0]             ps2_key_i;
	logic [joy_w-1:0]        joy_0_i;
	logic [joy_w-1:0]        joy_1_i;
	logic                    ioctl_download_i;
	logic                    ioctl_wr_i;
	logic [7:0]              ioctl_index_i;
	logic [ioctl_addr_w-1:0] ioctl_addr_i;
	logic [cart_addr_w-1:0]  cart_addr_i;
	logic                    cart_bank0_i;
	logic                    cart_bank1_i;
	logic                    cart_psen_n_i;
	logic                    cart_cs_n_i;
	logic [char_addr_w-1:0]  char_addr_i;
	logic                    vdc_r_i;
	logic                    vdc_g_i;
	logic                    vdc_b_i;
	logic                    vdc_luma_i;
	logic                    cpu_en_o;
	logic                    vdc_en_o;
	logic                    key_ready_o;
	logic [7:0]              key_ascii_o;
	logic                    key_released_o;
	logic [1:0]              joy_up_n_o;
	logic [1:0]              joy_down_n_o;
	logic [1:0]              joy_left_n_o;
	logic [1:0]              joy_right_n_o;
	logic [1:0]              joy_action_n_o;
	logic                    joy_reset_n_o;
	logic [rom_addr_w-1:0]   rom_addr_o;
	logic                    rom_wren_o;
	logic                    rom_rden_o;
	logic [char_addr_w-1:0]  char_addr_o;
	logic                    char_wren_o;
	logic [color_w-1:0]      color_o;

	entry_t      stim_q[$];
	int          err_cnt[6] = '{0, 0, 0, 0, 0, 0};
	int          n_checks = 0;
	int          cycle_cnt = 0;
	int          cycle_limit = 0;
	logic [15:0] lfsr_state = 16'd35011;

	vp_glue_top dut_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(clk_period / 2) clk_sys = ~clk_sys;
	end

	//////////////////////////////////////////////////
	// Helpers

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output logic [15:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			bits       = {bits[14:0], lfsr_state[0]}; // One step per bit
		end
	endtask

	task automatic check_equal(input kind_e k, input string what, input logic [31:0] got,
		input logic [31:0] want);
		n_checks++;
		assert (got === want) else begin
			err_cnt[int'(k)]++;
			$display("** Error at %0t: %s %s is 0x%0h, expected 0x%0h", $time, k.name(),
				what, got, want);
		end
	endtask

	// Bank layouts of the cartridge ROM
	function automatic logic [13:0] expect_rom_addr(input cart_layout_e lay,
		input logic [11:0] a, input logic b0, input logic b1);
		case (lay)
			layout_xrom: return {2'b00, a};
			layout_4k:   return {2'b00, b0, a[11], a[9:0]};
			layout_8k:   return {1'b0, b1, b0, a[11], a[9:0]};
			layout_12k:  return {b1, b0, a};
			default:     return {3'b000, a[11], a[9:0]};
		endcase
	endfunction

	// Direction pairs ordered action, right, left, down, up from the top
	function automatic logic [31:0] joy_want(input logic [7:0] ascii, input logic ready,
		input logic released, input logic [9:0] dirs_n, input logic reset_n);
		return {11'd0, reset_n, dirs_n, released, ready, ascii};
	endfunction

	function automatic int entry_cycles(input entry_t e);
		case (e.kind)
			kind_dl:  return int'(e.stim[15:0]) + 2;
			kind_map: return int'(e.stim[15:0]);
			default:  return 3;
		endcase
	endfunction

	task automatic add_entry(input kind_e k, input logic [39:0] s, input logic [31:0] w);
		entry_t e;
		e.kind = k;
		e.stim = s;
		e.want = w;
		stim_q.push_back(e);
	endtask

	// Image download followed by random reads in the resulting layout
	task automatic add_cart_case(input logic [7:0] idx, input logic [15:0] n_bytes,
		input cart_layout_e lay);
		add_entry(kind_dl, {16'd0, idx, n_bytes}, 32'(idx[1:0] == 2'd3));
		add_entry(kind_map, 40'd64, 32'(lay));
	endtask

	task automatic build_table();
		// Key stim is {pressed, code} and the last one is a release
		add_entry(kind_key, 40'h216, 32'h31);
		add_entry(kind_key, 40'h21C, 32'h61);
		add_entry(kind_key, 40'h229, 32'h20);
		add_entry(kind_key, 40'h25A, 32'h0A);
		add_entry(kind_key, 40'h20E, 32'h00); // Not in the table
		add_entry(kind_key, 40'h066, 32'h08);
		// Joystick stim is {swap, joy_1, joy_0}
		add_entry(kind_joy, {8'd0, 16'h0000, 16'h0240}, joy_want(8'h31, 1, 0, 10'h3FF, 1));
		add_entry(kind_joy, {8'd0, 16'h0000, 16'h0000}, joy_want(8'h31, 1, 1, 10'h3FF, 1));
		add_entry(kind_joy, {8'd0, 16'h0000, 16'h0008}, joy_want(8'h00, 0, 1, 10'h3FD, 1));
		add_entry(kind_joy, {8'd1, 16'h0000, 16'h0008}, joy_want(8'h00, 0, 1, 10'h3FE, 1));
		add_entry(kind_joy, {8'd0, 16'h0020, 16'h0020}, joy_want(8'h00, 0, 1, 10'h3FF, 0));
		add_entry(kind_joy, {8'd0, 16'h0011, 16'h0006}, joy_want(8'h00, 0, 1, 10'h297, 1));
		add_entry(kind_joy, {8'd1, 16'h0011, 16'h0006}, joy_want(8'h00, 0, 1, 10'h16B, 1));
		add_entry(kind_joy, {8'd1, 16'h8000, 16'h0000}, joy_want(8'h30, 1, 0, 10'h3FF, 1));
		add_entry(kind_joy, {8'd0, 16'h0000, 16'h0000}, joy_want(8'h30, 1, 1, 10'h3FF, 1));
		add_cart_case(8'd0, 16'd4096, layout_4k);
		add_cart_case(8'd0, 16'd8192, layout_8k);
		add_cart_case(8'd0, 16'd16384, layout_12k);
		add_cart_case(8'd0, 16'd2048, layout_plain);
		add_cart_case(8'd2, 16'd1024, layout_xrom);
		add_cart_case(8'd3, 16'd512, layout_plain); // Font clears the XROM flag
		// Colour stim is {pal_colors, R, G, B, luma}
		add_entry(kind_color, 40'h00, 32'h000000);
		add_entry(kind_color, 40'h10, 32'h000000);
		add_entry(kind_color, 40'h0F, 32'hFFFFFF);
		add_entry(kind_color, 40'h1F, 32'hFFFFFF);
		add_entry(kind_color, 40'h08, 32'h790000);
		add_entry(kind_color, 40'h18, 32'hB60000);
		add_entry(kind_color, 40'h01, 32'h676767);
		add_entry(kind_color, 40'h11, 32'h494949);
	endtask

	//////////////////////////////////////////////////
	// Stimulus per kind

	task automatic check_enables(input int offset, input int cpu_gap, input int vdc_gap,
		input int n_cycles);
		logic cpu_want;
		logic vdc_want;
		for (int n = 1; n <= n_cycles; n++) begin
			@(negedge clk_sys);
			cpu_want = (n > offset) && ((n - offset) % cpu_gap == 0);
			vdc_want = (n > offset) && ((n - offset) % vdc_gap == 0);
			check_equal(kind_clk, $sformatf("cpu_en cycle %0d", n), 32'(cpu_en_o),
				32'(cpu_want));
			check_equal(kind_clk, $sformatf("vdc_en cycle %0d", n), 32'(vdc_en_o),
				32'(vdc_want));
		end
	endtask

	task automatic apply_key(input entry_t e);
		@(negedge clk_sys);
		ps2_key_i = {~ps2_key_i[10], e.stim[9:0]}; // Toggle strobe
		@(negedge clk_sys);
		check_equal(kind_key, "key_ready", 32'(key_ready_o), 32'h1);
		check_equal(kind_key, "key_ascii", 32'(key_ascii_o), e.want);
		check_equal(kind_key, "key_released", 32'(key_released_o), 32'(!e.stim[9]));
		@(negedge clk_sys);
		check_equal(kind_key, "key_ready end", 32'(key_ready_o), 32'h0);
	endtask

	task automatic apply_joy(input entry_t e);
		@(negedge clk_sys);
		joy_0_i    = e.stim[15:0];
		joy_1_i    = e.stim[31:16];
		joy_swap_i = e.stim[32];
		#(clk_period / 4); // Directions are combinational
		check_equal(kind_joy, "joy_up_n", 32'(joy_up_n_o), 32'(e.want[11:10]));
		check_equal(kind_joy, "joy_down_n", 32'(joy_down_n_o), 32'(e.want[13:12]));
		check_equal(kind_joy, "joy_left_n", 32'(joy_left_n_o), 32'(e.want[15:14]));
		check_equal(kind_joy, "joy_right_n", 32'(joy_right_n_o), 32'(e.want[17:16]));
		check_equal(kind_joy, "joy_action_n", 32'(joy_action_n_o), 32'(e.want[19:18]));
		check_equal(kind_joy, "joy_reset_n", 32'(joy_reset_n_o), 32'(e.want[20]));
		@(negedge clk_sys);
		check_equal(kind_joy, "key_ready", 32'(key_ready_o), 32'(e.want[8]));
		check_equal(kind_joy, "key_released", 32'(key_released_o), 32'(e.want[9]));
		if (e.want[8]) begin
			check_equal(kind_joy, "key_ascii", 32'(key_ascii_o), 32'(e.want[7:0]));
			@(negedge clk_sys);
			check_equal(kind_joy, "key_ready end", 32'(key_ready_o), 32'h0);
		end
	endtask

	task automatic apply_download(input entry_t e);
		int   n_bytes;
		logic font;
		n_bytes = int'(e.stim[15:0]);
		font    = e.want[0];
		@(negedge clk_sys);
		ioctl_index_i    = e.stim[23:16];
		ioctl_download_i = 1'b1;
		ioctl_wr_i       = 1'b0;
		ioctl_addr_i     = '0;
		#(clk_period / 4);
		check_equal(kind_dl, "rom_wren idle", 32'(rom_wren_o), 32'h0);
		check_equal(kind_dl, "char_wren idle", 32'(char_wren_o), 32'h0);
		for (int n = 0; n < n_bytes; n++) begin
			@(negedge clk_sys);
			ioctl_addr_i = ioctl_addr_w'(n);
			ioctl_wr_i   = 1'b1;
			#(clk_period / 4);
			if (font) begin
				check_equal(kind_dl, "char_wren", 32'(char_wren_o), 32'h1);
				check_equal(kind_dl, "char_addr", 32'(char_addr_o), 32'(n % 512));
				check_equal(kind_dl, "rom_wren font", 32'(rom_wren_o), 32'h0);
			end else begin
				check_equal(kind_dl, "rom_wren", 32'(rom_wren_o), 32'h1);
				check_equal(kind_dl, "rom_addr", 32'(rom_addr_o), 32'(n % 16384));
			end
		end
		@(negedge clk_sys);
		ioctl_wr_i       = 1'b0;
		ioctl_download_i = 1'b0;
	endtask

	task automatic apply_map(input entry_t e);
		cart_layout_e lay;
		logic [15:0]  r;
		logic         rden;
		lay = cart_layout_e'(e.want[2:0]);
		for (int s = 0; s < int'(e.stim[15:0]); s++) begin
			@(negedge clk_sys);
			take_bits(12, r);
			cart_addr_i = r[11:0];
			take_bits(4, r);
			{cart_psen_n_i, cart_cs_n_i, cart_bank1_i, cart_bank0_i} = r[3:0];
			take_bits(12, r);
			char_addr_i = r[11:0];
			if (lay == layout_xrom)
				rden = cart_psen_n_i && !(cart_cs_n_i && cart_bank0_i);
			else
				rden = !cart_psen_n_i;
			#(clk_period / 4);
			check_equal(kind_map, $sformatf("rom_addr %s", lay.name()), 32'(rom_addr_o),
				32'(expect_rom_addr(lay, cart_addr_i, cart_bank0_i, cart_bank1_i)));
			check_equal(kind_map, "rom_rden", 32'(rom_rden_o), 32'(rden));
			check_equal(kind_map, "char_addr", 32'(char_addr_o), 32'(char_addr_i));
		end
	endtask

	task automatic apply_color(input entry_t e);
		@(negedge clk_sys);
		pal_colors_i = e.stim[4];
		{vdc_r_i, vdc_g_i, vdc_b_i, vdc_luma_i} = e.stim[3:0]; // R is the MSB
		@(negedge clk_sys);
		check_equal(kind_color, $sformatf("color idx %0d pal %0d", e.stim[3:0], e.stim[4]),
			32'(color_o), e.want);
	endtask

	function automatic int total_errors();
		int sum;
		sum = 0;
		foreach (err_cnt[i])
			sum += err_cnt[i];
		return sum;
	endfunction

	task automatic print_counts();
		$display("Checks %0d, errors clk %0d key %0d joy %0d dl %0d map %0d color %0d", n_checks,
			err_cnt[0], err_cnt[1], err_cnt[2], err_cnt[3], err_cnt[4], err_cnt[5]);
	endtask

	//////////////////////////////////////////////////
	// Main sequence

	initial begin
		int table_cycles;
		reset            = 1'b1;
		pal_i            = 1'b0;
		pal_colors_i     = 1'b0;
		joy_swap_i       = 1'b0;
		ps2_key_i        = '0;
		joy_0_i          = '0;
		joy_1_i          = '0;
		ioctl_download_i = 1'b0;
		ioctl_wr_i       = 1'b0;
		ioctl_index_i    = '0;
		ioctl_addr_i     = '0;
		cart_addr_i      = '0;
		{cart_psen_n_i, cart_cs_n_i, cart_bank1_i, cart_bank0_i} = 4'b1100;
		char_addr_i      = '0;
		{vdc_r_i, vdc_g_i, vdc_b_i, vdc_luma_i} = 4'h0;

		build_table();
		table_cycles = 0;
		foreach (stim_q[i])
			table_cycles += entry_cycles(stim_q[i]);
		cycle_limit = 2 * table_cycles + clk_phase_cycles + 8;

		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		check_enables(0, 8, 6, 48);
		pal_i = 1'b1; // PAL switch restarts the dividers
		check_enables(1, 12, 10, 60);

		foreach (stim_q[i]) begin
			case (stim_q[i].kind)
				kind_key:   apply_key(stim_q[i]);
				kind_joy:   apply_joy(stim_q[i]);
				kind_dl:    apply_download(stim_q[i]);
				kind_map:   apply_map(stim_q[i]);
				kind_color: apply_color(stim_q[i]);
				default:    ;
			endcase
		end

		print_counts();
		if (total_errors() == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	// Watchdog
	initial begin
		@(posedge clk_sys);
		while (cycle_cnt < cycle_limit) begin
			@(posedge clk_sys);
			cycle_cnt++;
		end
		$display("Timeout: tests did not finish within %0d clock cycles", cycle_limit);
		print_counts();
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
hw/vp_pkg.sv
hw/vp_clock_enables.sv
hw/vp_input_encoder.sv
hw/vp_cart_mapper.sv
hw/vp_palette.sv
hw/vp_glue_top.sv
sim/tb_vp_glue.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/10ps --top-module tb_vp_glue \
	-f vlog.f -o tb_vp_glue

./obj_dir/tb_vp_glue | tee sim.log

if grep -qx "RESULT: PASS" sim.log; then
	echo "Simulation passed"
	exit 0
fi

echo "Simulation failed, see sim.log"
exit 1
